// ==== design/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

    parameter int xlen = 32;                    // data and address width

    typedef logic [4:0]      reg_addr_t;        // register index
    typedef logic [xlen-1:0] word_t;            // one data word

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000,                          // also sub with funct7 alt
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,                          // srl or sra
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // low eight follow funct3, bit 3 marks the alternate form
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    typedef enum logic [3:0] {
        fetch_addr, fetch_wait, fetch_latch, decode,
        alu_imm, alu_reg, lui_wb, branch, jump,
        calc_addr, load_wait, load_wb, store_wait, store_done
    } ctrl_state_t;

    typedef enum logic {a_rs1, a_pc} a_sel_t;

    typedef enum logic [2:0] {b_rs2, b_i_imm, b_s_imm, b_b_imm, b_j_imm} b_sel_t;

    typedef enum logic [2:0] {wb_alu, wb_cmp, wb_u_imm, wb_pc_plus4, wb_mem} wb_sel_t;

    // everything the control FSM drives into the datapath
    typedef struct packed {
        logic           load_pc;
        logic           pc_from_alu;            // else pc + 4
        logic           load_ir;
        logic           load_mar;               // also loads the data-out register
        logic           addr_from_alu;          // else pc
        logic           load_mdr;
        logic           load_regfile;
        wb_sel_t        wb_sel;
        a_sel_t         a_sel;
        b_sel_t         b_sel;
        alu_op_t        alu_op;
        logic           cmp_imm;                // compare against i_imm instead of rs2
        branch_funct3_t cmp_op;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== design/rv32_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_alu import rv32_pkg::*; (
    input  alu_op_t        alu_op,
    input  word_t          a,
    input  word_t          b,
    input  branch_funct3_t cmp_op,
    input  word_t          cmp_b,
    output word_t          result,
    output logic           br_en
);

    logic [4:0] shamt;                          // rv32 shifts use five bits
    logic       eq;
    logic       lt;
    logic       ltu;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

    // comparator, shared by branches and slt/sltu writeback
    assign eq  = (a == cmp_b);
    assign lt  = ($signed(a) < $signed(cmp_b));
    assign ltu = (a < cmp_b);

    always_comb begin
        case (cmp_op)
            beq:     br_en = eq;
            bne:     br_en = !eq;
            blt:     br_en = lt;
            bge:     br_en = !lt;
            bltu:    br_en = ltu;
            bgeu:    br_en = !ltu;
            default: br_en = 1'b0;              // undefined funct3 never taken
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv32_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_regfile import rv32_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     wdata,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [1:31];                         // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin    // writes to x0 dropped
            regs[rd] <= wdata;
        end
    end

    // combinational reads, x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== design/rv32_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_datapath import rv32_pkg::*; #(
    parameter word_t reset_vector = '0
) (
    input  logic  clk,
    input  logic  rst,
    input  ctrl_t ctrl,
    input  word_t mem_rdata,
    output word_t ir,
    output logic  br_en,
    output word_t addr,
    output word_t wdata
);

    word_t pc;
    word_t pc_plus4;
    word_t mar;                                 // memory address register
    word_t data_out;                            // store data, held for the request
    word_t mdr;                                 // memory data register
    word_t rs1_data;
    word_t rs2_data;
    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;
    word_t alu_a;
    word_t alu_b;
    word_t cmp_b;
    word_t alu_result;
    word_t rd_data;

    // immediates straight from the instruction register
    assign i_imm = {{20{ir[31]}}, ir[31:20]};
    assign s_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign b_imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign u_imm = {ir[31:12], 12'b0};
    assign j_imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign pc_plus4 = pc + word_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_vector;
        end else if (ctrl.load_pc) begin
            pc <= ctrl.pc_from_alu ? alu_result : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir) begin
            ir <= mdr;                          // fetched word sits in mdr first
        end
        if (ctrl.load_mar) begin
            mar      <= ctrl.addr_from_alu ? alu_result : pc;
            data_out <= rs2_data;
        end
        if (ctrl.load_mdr) begin
            mdr <= mem_rdata;                   // only set in the transfer cycle
        end
    end

    assign addr  = mar;
    assign wdata = data_out;

    rv32_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .we       (ctrl.load_regfile),
        .rd       (ir[11:7]),
        .wdata    (rd_data),
        .rs1      (ir[19:15]),
        .rs2      (ir[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = (ctrl.a_sel == a_pc) ? pc : rs1_data;

    always_comb begin
        case (ctrl.b_sel)
            b_rs2:   alu_b = rs2_data;
            b_s_imm: alu_b = s_imm;
            b_b_imm: alu_b = b_imm;
            b_j_imm: alu_b = j_imm;
            default: alu_b = i_imm;
        endcase
    end

    assign cmp_b = ctrl.cmp_imm ? i_imm : rs2_data; // slti/sltiu use i_imm

    rv32_alu u_alu (
        .alu_op (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cmp_op (ctrl.cmp_op),
        .cmp_b  (cmp_b),
        .result (alu_result),
        .br_en  (br_en)
    );

    always_comb begin
        case (ctrl.wb_sel)
            wb_cmp:      rd_data = {{(xlen-1){1'b0}}, br_en};
            wb_u_imm:    rd_data = u_imm;
            wb_pc_plus4: rd_data = pc_plus4;    // pc still holds this instruction
            wb_mem:      rd_data = mdr;
            default:     rd_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv32_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_control import rv32_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t ir,
    input  logic  br_en,
    input  logic  mem_ready,
    output ctrl_t ctrl,
    output logic  mem_valid,
    output logic  mem_write
);

    localparam logic [6:0] funct7_alt = 7'b0100000; // selects sub and sra

    ctrl_state_t   state;
    ctrl_state_t   next_state;
    opcode_t       opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    arith_funct3_t arith_funct3;
    logic          br_taken;                    // comparator result sampled in decode

    assign opcode       = opcode_t'(ir[6:0]);
    assign funct3       = ir[14:12];
    assign funct7       = ir[31:25];
    assign arith_funct3 = arith_funct3_t'(funct3);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_addr;
            br_taken <= 1'b0;
        end else begin
            state <= next_state;
            if (state == decode) begin
                br_taken <= br_en;              // a_sel is rs1 here, so this is rs1 vs rs2
            end
        end
    end

    // shared by alu_imm and alu_reg, only add/sub differs between them
    function automatic void set_arith(input logic is_reg);
        ctrl.load_regfile = 1'b1;
        ctrl.load_pc      = 1'b1;
        ctrl.alu_op       = alu_op_t'({1'b0, funct3});
        case (arith_funct3)
            sr:  ctrl.alu_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
            add: ctrl.alu_op = (is_reg && funct7 == funct7_alt) ? alu_sub : alu_add;
            slt: begin
                ctrl.wb_sel = wb_cmp;
                ctrl.cmp_op = blt;
            end
            sltu: begin
                ctrl.wb_sel = wb_cmp;
                ctrl.cmp_op = bltu;
            end
            default: ;
        endcase
    endfunction

    always_comb begin
        ctrl.load_pc       = 1'b0;
        ctrl.pc_from_alu   = 1'b0;
        ctrl.load_ir       = 1'b0;
        ctrl.load_mar      = 1'b0;
        ctrl.addr_from_alu = 1'b0;
        ctrl.load_mdr      = 1'b0;
        ctrl.load_regfile  = 1'b0;
        ctrl.wb_sel        = wb_alu;
        ctrl.a_sel         = a_rs1;
        ctrl.b_sel         = b_i_imm;
        ctrl.alu_op        = alu_add;
        ctrl.cmp_imm       = 1'b0;
        ctrl.cmp_op        = branch_funct3_t'(funct3); // branch condition by default
        mem_valid          = 1'b0;
        mem_write          = 1'b0;
        case (state)
            fetch_addr: ctrl.load_mar = 1'b1;   // mar <= pc
            fetch_wait: begin
                mem_valid     = 1'b1;
                ctrl.load_mdr = mem_ready;
            end
            fetch_latch: ctrl.load_ir = 1'b1;
            alu_imm: begin
                ctrl.cmp_imm = 1'b1;
                set_arith(1'b0);
            end
            alu_reg: begin
                ctrl.b_sel = b_rs2;
                set_arith(1'b1);
            end
            lui_wb: begin
                ctrl.load_regfile = 1'b1;
                ctrl.wb_sel       = wb_u_imm;
                ctrl.load_pc      = 1'b1;
            end
            branch: begin
                ctrl.a_sel       = a_pc;        // target = pc + b_imm
                ctrl.b_sel       = b_b_imm;
                ctrl.load_pc     = 1'b1;
                ctrl.pc_from_alu = br_taken;
            end
            jump: begin
                ctrl.a_sel        = a_pc;
                ctrl.b_sel        = b_j_imm;
                ctrl.load_pc      = 1'b1;
                ctrl.pc_from_alu  = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.wb_sel       = wb_pc_plus4;
            end
            calc_addr: begin
                ctrl.b_sel         = (opcode == op_store) ? b_s_imm : b_i_imm;
                ctrl.load_mar      = 1'b1;      // data-out takes rs2 alongside
                ctrl.addr_from_alu = 1'b1;
            end
            load_wait: begin
                mem_valid     = 1'b1;
                ctrl.load_mdr = mem_ready;
            end
            load_wb: begin
                ctrl.load_regfile = 1'b1;
                ctrl.wb_sel       = wb_mem;
                ctrl.load_pc      = 1'b1;
            end
            store_wait: begin
                mem_valid = 1'b1;
                mem_write = 1'b1;
            end
            store_done: ctrl.load_pc = 1'b1;
            default: ;                          // decode drives nothing
        endcase
    end

    always_comb begin
        next_state = fetch_addr;
        case (state)
            fetch_addr:  next_state = fetch_wait;
            fetch_wait:  next_state = mem_ready ? fetch_latch : fetch_wait;
            fetch_latch: next_state = decode;
            decode: begin
                case (opcode)
                    op_imm:   next_state = alu_imm;
                    op_reg:   next_state = alu_reg;
                    op_lui:   next_state = lui_wb;
                    op_br:    next_state = branch;
                    op_jal:   next_state = jump;
                    op_load,
                    op_store: next_state = calc_addr;
                    default:  next_state = fetch_addr; // unknown opcode refetches
                endcase
            end
            calc_addr:  next_state = (opcode == op_store) ? store_wait : load_wait;
            load_wait:  next_state = mem_ready ? load_wb : load_wait;
            store_wait: next_state = mem_ready ? store_done : store_wait;
            default:    next_state = fetch_addr;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv32_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_core import rv32_pkg::*; #(
    parameter word_t reset_vector = '0          // first fetch address
) (
    input  logic     clk,
    input  logic     rst,
    output logic     mem_valid,
    output mem_req_t mem_req,
    input  logic     mem_ready,
    input  word_t    mem_rdata
);

    ctrl_t ctrl;
    word_t ir;
    logic  br_en;
    word_t addr;
    word_t wdata;
    logic  mem_write;

    rv32_control u_control (
        .clk       (clk),
        .rst       (rst),
        .ir        (ir),
        .br_en     (br_en),
        .mem_ready (mem_ready),
        .ctrl      (ctrl),
        .mem_valid (mem_valid),
        .mem_write (mem_write)
    );

    rv32_datapath #(
        .reset_vector (reset_vector)
    ) u_datapath (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .ir        (ir),
        .br_en     (br_en),
        .addr      (addr),
        .wdata     (wdata)
    );

    // addr and wdata come from registers, so the request holds while waiting
    assign mem_req = '{addr: addr, wdata: wdata, write: mem_write};

endmodule

`default_nettype wire

// ==== tests/tb_rv32_tasks.svh ====
`ifndef tb_rv32_tasks_svh
`define tb_rv32_tasks_svh

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1); // galois step with taps 16 14 13 11
endfunction

function automatic logic [1:0] draw_waits();
    logic [1:0] r;
    r = '0;
    for (int i = 0; i < 2; i++) begin
        lfsr = lfsr_next(lfsr);                 // one step per bit
        r    = {r[0], lfsr[0]};
    end
    return r;
endfunction

function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic word_t bool_word(input logic c);
    return {31'b0, c};
endfunction

function automatic word_t fill_word(input int i);
    return word_t'(i) * 32'h9e37_79b1;          // every address bit matters
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                input logic [2:0] f3, input reg_addr_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
endfunction

function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
endfunction

function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, op_lui};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

// branch outcome by the rv32i rules
function automatic logic branch_rule(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error: %s got %h expected %h", name, got, exp);
    end
endtask

task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error: %s got %h expected %h", name, got, exp);
    end
endtask

task automatic emit(input word_t w);
    prog.push_back(w);
endtask

// store rd into the next result slot and remember what it must hold
task automatic store_result(input reg_addr_t rd, input word_t exp);
    emit(enc_s(12'(result_base + 4 * exp_q.size()), rd, 5'd0));
    exp_q.push_back(exp);
endtask

task automatic do_op(input word_t instr, input reg_addr_t rd, input word_t exp);
    emit(instr);
    store_result(rd, exp);
endtask

task automatic run_program(input string name);
    int err_start;
    err_start = errors;
    emit(enc_s(done_addr[11:0], 5'd0, 5'd0));  // end marker store
    @(negedge clk);
    rst = 1'b1;
    @(negedge clk);                             // core quiet before reloading memory
    for (int i = 0; i < mem_words; i++) begin
        mem[i] = fill_word(i);
    end
    foreach (prog[i]) begin
        mem[i] = prog[i];
    end
    repeat (9) @(negedge clk);
    done = 1'b0;
    rst  = 1'b0;
    while (!done) begin
        @(negedge clk);
    end
    foreach (exp_q[k]) begin
        check_word($sformatf("result[%0d]", k), mem[result_word + k], exp_q[k]);
    end
    $display("%s, waits %s: %s", name, waits_on ? "on" : "off",
             (errors == err_start) ? "ok" : "FAILED");
    prog.delete();
    exp_q.delete();
endtask

task automatic test_imm();
    word_t a;
    word_t b;
    a = 32'hffff_fffb;
    b = 32'h0000_0123;
    emit(enc_i(12'hffb, 5'd0, add, 5'd1, op_imm));
    emit(enc_i(12'h123, 5'd0, add, 5'd2, op_imm));
    do_op(enc_i(12'd100, 5'd1, add, 5'd3, op_imm), 5'd3, a + sext12(12'd100));
    do_op(enc_i(12'd5, 5'd1, slt, 5'd4, op_imm), 5'd4,
          bool_word($signed(a) < $signed(sext12(12'd5)))); // unsigned would give 0
    do_op(enc_i(12'hffc, 5'd2, sltu, 5'd5, op_imm), 5'd5,
          bool_word(b < sext12(12'hffc)));      // signed would give 0
    do_op(enc_i(12'd5, 5'd2, slt, 5'd6, op_imm), 5'd6,
          bool_word($signed(b) < $signed(sext12(12'd5))));
    do_op(enc_i(12'h055, 5'd1, axor, 5'd7, op_imm), 5'd7, a ^ sext12(12'h055));
    do_op(enc_i(12'h70f, 5'd2, aor, 5'd8, op_imm), 5'd8, b | sext12(12'h70f));
    do_op(enc_i(12'h0f0, 5'd1, aand, 5'd9, op_imm), 5'd9, a & sext12(12'h0f0));
    do_op(enc_i(12'h004, 5'd1, sll, 5'd10, op_imm), 5'd10, a << 4);
    do_op(enc_i(12'h004, 5'd1, sr, 5'd11, op_imm), 5'd11, a >> 4);
    do_op(enc_i(12'h404, 5'd1, sr, 5'd12, op_imm), 5'd12, word_t'($signed(a) >>> 4));
    run_program("test_imm");
endtask

task automatic test_reg();
    word_t a;
    word_t b;
    a = 32'hffff_fffb;
    b = 32'h0000_0123;
    emit(enc_i(12'hffb, 5'd0, add, 5'd1, op_imm));
    emit(enc_i(12'h123, 5'd0, add, 5'd2, op_imm));
    emit(enc_i(12'd37, 5'd0, add, 5'd3, op_imm)); // only the low five bits shift
    do_op(enc_r(7'h00, 5'd2, 5'd1, add, 5'd4), 5'd4, a + b);
    do_op(enc_r(7'h20, 5'd2, 5'd1, add, 5'd5), 5'd5, a - b);
    do_op(enc_r(7'h00, 5'd3, 5'd1, sll, 5'd6), 5'd6, a << 5);
    do_op(enc_r(7'h00, 5'd3, 5'd1, sr, 5'd7), 5'd7, a >> 5);
    do_op(enc_r(7'h20, 5'd3, 5'd1, sr, 5'd8), 5'd8, word_t'($signed(a) >>> 5));
    do_op(enc_r(7'h00, 5'd2, 5'd1, slt, 5'd9), 5'd9, bool_word($signed(a) < $signed(b)));
    do_op(enc_r(7'h00, 5'd2, 5'd1, sltu, 5'd10), 5'd10, bool_word(a < b));
    do_op(enc_r(7'h00, 5'd2, 5'd1, axor, 5'd11), 5'd11, a ^ b);
    do_op(enc_r(7'h00, 5'd2, 5'd1, aor, 5'd12), 5'd12, a | b);
    do_op(enc_r(7'h00, 5'd2, 5'd1, aand, 5'd13), 5'd13, a & b);
    do_op(enc_r(7'h00, 5'd2, 5'd1, add, 5'd0), 5'd0, 32'h0); // x0 stays zero
    run_program("test_reg");
endtask

task automatic test_mem();
    do_op(enc_u(20'h12345, 5'd1), 5'd1, 32'h1234_5000);
    do_op(enc_i(12'h678, 5'd1, add, 5'd1, op_imm), 5'd1, 32'h1234_5678);
    do_op(enc_u(20'habcde, 5'd6), 5'd6, 32'habcd_e000);
    emit(enc_i(12'h500, 5'd0, add, 5'd2, op_imm));
    emit(enc_i(12'h510, 5'd0, add, 5'd3, op_imm));
    emit(enc_s(12'd8, 5'd1, 5'd2));            // 0x508
    emit(enc_s(12'hffc, 5'd6, 5'd2));          // 0x4fc
    emit(enc_i(12'hff8, 5'd3, 3'b010, 5'd4, op_load)); // 0x510 - 8
    store_result(5'd4, 32'h1234_5678);
    emit(enc_i(12'h4fc, 5'd0, 3'b010, 5'd5, op_load));
    store_result(5'd5, 32'habcd_e000);
    emit(enc_i(12'h508, 5'd0, 3'b010, 5'd7, op_load));
    store_result(5'd7, 32'h1234_5678);
    run_program("test_mem");
endtask

task automatic test_branch();
    logic [2:0] f3s [12] = '{beq, beq, bne, bne, blt, blt, bge, bge, bltu, bltu, bgeu, bgeu};
    reg_addr_t  r1s [12] = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    reg_addr_t  r2s [12] = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    word_t      vals [4] = '{32'h0, 32'hffff_fffb, 32'h3, 32'hffff_fffb};
    logic       taken;
    emit(enc_i(12'hffb, 5'd0, add, 5'd1, op_imm));
    emit(enc_i(12'd3, 5'd0, add, 5'd2, op_imm));
    emit(enc_i(12'hffb, 5'd0, add, 5'd3, op_imm));
    for (int k = 0; k < 12; k++) begin
        taken = branch_rule(f3s[k], vals[r1s[k][1:0]], vals[r2s[k][1:0]]);
        emit(enc_b(13'd12, r2s[k], r1s[k], f3s[k]));
        emit(enc_i(12'(256 + k), 5'd0, add, 5'd5, op_imm)); // fall-through marker
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(12'(512 + k), 5'd0, add, 5'd5, op_imm)); // taken marker
        store_result(5'd5, taken ? word_t'(512 + k) : word_t'(256 + k));
    end
    run_program("test_branch");
endtask

task automatic test_jal();
    word_t pc;
    pc = word_t'(4 * prog.size());
    emit(enc_j(21'd12, 5'd7));
    emit(enc_i(12'd99, 5'd0, add, 5'd8, op_imm)); // skipped
    emit(enc_i(12'd98, 5'd0, add, 5'd8, op_imm)); // skipped
    store_result(5'd7, pc + 4);
    store_result(5'd8, 32'h0);
    run_program("test_jal");
endtask

`endif

// ==== tests/tb_rv32_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv32_core import rv32_pkg::*; ();

    localparam int    mem_words          = 512;           // covers 0x000 to 0x7fc
    localparam word_t result_base        = 32'h0000_0400; // results written here
    localparam int    result_word        = 256;           // result_base in words
    localparam word_t done_addr          = 32'h0000_07fc; // a store here ends a test
    localparam int    max_instr          = 80;
    localparam int    worst_instr_cycles = 16;            // fetch and data access with 3 waits each
    localparam int    cycle_limit        = 2 * 5 * (14 + max_instr * worst_instr_cycles);

    logic     clk;
    logic     rst;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_ready;
    word_t    mem_rdata;

    word_t       mem [0:mem_words-1];
    logic [8:0]  mem_idx;
    logic        done;                          // done store seen
    logic        waits_on;                      // random wait states enabled
    logic        busy;                          // request accepted, not yet transferred
    mem_req_t    held_req;                      // request as first seen
    int          wait_left;
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;
    word_t       prog [$];
    word_t       exp_q [$];

    `include "tb_rv32_tasks.svh"

    rv32_core #(
        .reset_vector (32'h0000_0000)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    always #2 clk = ~clk;                       // 4 ns period

    assign mem_idx = mem_req.addr[10:2];

    // memory model, drives ready and read data on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            mem_ready = 1'b0;
            busy      = 1'b0;
        end else if (mem_ready) begin
            mem_ready = 1'b0;                   // transfer took place on the last rising edge
            busy      = 1'b0;
        end else if (mem_valid) begin
            if (!busy) begin
                busy      = 1'b1;
                held_req  = mem_req;
                wait_left = waits_on ? int'(draw_waits()) : 0;
            end else begin
                check_req("mem_req", mem_req, held_req);
            end
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                mem_rdata = mem[mem_idx];
                if (mem_req.write) begin
                    mem[mem_idx] = mem_req.wdata;
                    if (mem_req.addr == done_addr) begin
                        done = 1'b1;
                    end
                end
            end else begin
                wait_left--;
            end
        end else if (busy) begin
            errors++;
            $display("mem_valid dropped before the memory accepted the request");
            busy = 1'b0;
        end
    end

    // run limit over all tests
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        mem_ready = 1'b0;
        mem_rdata = '0;
        done      = 1'b0;
        busy      = 1'b0;
        wait_left = 0;
        lfsr      = 16'd82;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        for (int pass = 0; pass < 2; pass++) begin
            waits_on = (pass == 1);             // second round under back-pressure
            test_imm();
            test_reg();
            test_mem();
            test_branch();
            test_jal();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv32_core.f ====
+incdir+tests
design/rv32_pkg.sv
design/rv32_alu.sv
design/rv32_regfile.sv
design/rv32_datapath.sv
design/rv32_control.sv
design/rv32_core.sv
tests/tb_rv32_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the rv32_core testbench with Verilator, run it and check the log.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_rv32_core \
    -Mdir "${build_dir}" -o tb_rv32_core \
    -f rv32_core.f
status=$?
if [ ${status} -ne 0 ]; then
    echo "verilator build failed with status ${status}"
    exit 1
fi

"./${build_dir}/tb_rv32_core" > "${log_file}" 2>&1
status=$?
cat "${log_file}"
if [ ${status} -ne 0 ]; then
    echo "simulation exited with status ${status}"
    exit 1
fi

if grep -q "All checks passed" "${log_file}"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see ${log_file}"
exit 1
